// File: cpuAlu.sv
`timescale 1ns/10ps
`default_nettype none

module cpuAlu (
	input  cpuPkg::aluOp_t                aluSel,
	input  logic [cpuPkg::dataWidth-1:0]  a,
	input  logic [cpuPkg::dataWidth-1:0]  b,
	output cpuPkg::aluResult_t            result
);

	logic [cpuPkg::dataWidth:0]   sum;
	logic [cpuPkg::dataWidth:0]   diff;
	logic [cpuPkg::dataWidth-1:0] value;
	logic                         carry;

	assign sum  = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b}; // MSB is the borrow

	always_comb begin
		value = b;
		carry = 1'b0;
		case (aluSel)
			cpuPkg::aluPass: value = b;
			cpuPkg::aluAdd: begin
				value = sum[cpuPkg::dataWidth-1:0];
				carry = sum[cpuPkg::dataWidth];
			end
			cpuPkg::aluSub: begin
				value = diff[cpuPkg::dataWidth-1:0];
				carry = diff[cpuPkg::dataWidth]; // Set when b > a
			end
			cpuPkg::aluAnd: value = a & b;
			cpuPkg::aluXor: value = a ^ b;
			default: value = b;
		endcase
	end

	assign result.value = value;
	assign result.zero  = (value == '0);
	assign result.carry = carry;

endmodule

`default_nettype wire

// File: cpuControl.sv
`timescale 1ns/10ps
`default_nettype none

module cpuControl (
	input  logic                            clk,
	input  logic                            nRst,
	input  logic                            start,
	input  logic [cpuPkg::dataWidth-1:0]    opcode,
	input  logic [cpuPkg::dataWidth-1:0]    operand,
	input  logic [cpuPkg::addrWidth-1:0]    pc,
	input  logic [cpuPkg::dataWidth-1:0]    acc,
	input  logic                            zero,
	input  logic                            carry,
	output cpuPkg::memReq_t                 cpuReq,
	output logic                            coreActive,
	output logic                            halted,
	output logic                            opLoad,
	output logic                            argLoad,
	output logic                            accLoad,
	output logic                            flagLoad,
	output logic                            carryLoad,
	output logic                            pcInc,
	output logic                            pcLoad,
	output logic                            pcClear,
	output logic                            outLoad,
	output logic                            immSel,
	output cpuPkg::aluOp_t                  aluSel
);

	cpuPkg::ctrlState_t state;
	cpuPkg::ctrlState_t nextState;
	logic               inExecute;

	assign inExecute  = (state == cpuPkg::stExecute);
	assign halted     = (state == cpuPkg::stHalted);
	assign coreActive = !halted;

	// Data access in execute, instruction fetch otherwise
	assign cpuReq.address = inExecute ? operand : pc;
	assign cpuReq.wdata   = acc;
	assign cpuReq.we      = inExecute && (opcode == cpuPkg::opSta);

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst)
			state <= cpuPkg::stHalted;
		else
			state <= nextState;
	end

	// --------------------------------------------------
	// Next state and strobes
	always_comb begin
		nextState = state;
		opLoad    = 1'b0;
		argLoad   = 1'b0;
		accLoad   = 1'b0;
		flagLoad  = 1'b0;
		carryLoad = 1'b0;
		pcInc     = 1'b0;
		pcLoad    = 1'b0;
		pcClear   = 1'b0;
		outLoad   = 1'b0;
		immSel    = 1'b0;
		aluSel    = cpuPkg::aluPass;
		case (state)
			cpuPkg::stHalted: begin
				if (start) begin
					pcClear   = 1'b1; // Always run from address 0
					nextState = cpuPkg::stFetchOp;
				end
			end
			cpuPkg::stFetchOp: begin
				opLoad    = 1'b1;
				pcInc     = 1'b1;
				nextState = cpuPkg::stFetchArg;
			end
			cpuPkg::stFetchArg: begin
				argLoad   = 1'b1;
				pcInc     = 1'b1;
				nextState = cpuPkg::stExecute;
			end
			cpuPkg::stExecute: begin
				nextState = cpuPkg::stFetchOp;
				case (opcode)
					cpuPkg::opLda, cpuPkg::opAnd, cpuPkg::opXor: begin
						accLoad  = 1'b1;
						flagLoad = 1'b1;
					end
					cpuPkg::opAdd, cpuPkg::opSub: begin
						accLoad   = 1'b1;
						flagLoad  = 1'b1;
						carryLoad = 1'b1;
					end
					cpuPkg::opLdi: begin
						accLoad  = 1'b1;
						flagLoad = 1'b1;
						immSel   = 1'b1;
					end
					cpuPkg::opJmp: pcLoad = 1'b1;
					cpuPkg::opJz:  pcLoad = zero;
					cpuPkg::opJc:  pcLoad = carry;
					cpuPkg::opOut: outLoad = 1'b1;
					cpuPkg::opHlt: nextState = cpuPkg::stHalted;
					default: ; // STA and unknown opcodes
				endcase
				case (opcode)
					cpuPkg::opAdd: aluSel = cpuPkg::aluAdd;
					cpuPkg::opSub: aluSel = cpuPkg::aluSub;
					cpuPkg::opAnd: aluSel = cpuPkg::aluAnd;
					cpuPkg::opXor: aluSel = cpuPkg::aluXor;
					default:       aluSel = cpuPkg::aluPass;
				endcase
			end
			default: nextState = cpuPkg::stHalted;
		endcase
	end

endmodule

`default_nettype wire

// File: cpuDatapath.sv
`timescale 1ns/10ps
`default_nettype none

module cpuDatapath (
	input  logic                            clk,
	input  logic                            nRst,
	input  logic [cpuPkg::dataWidth-1:0]    rdata,
	input  logic                            opLoad,
	input  logic                            argLoad,
	input  logic                            accLoad,
	input  logic                            flagLoad,
	input  logic                            carryLoad,
	input  logic                            pcInc,
	input  logic                            pcLoad,
	input  logic                            pcClear,
	input  logic                            outLoad,
	input  logic                            immSel,
	input  cpuPkg::aluOp_t                  aluSel,
	output logic [cpuPkg::dataWidth-1:0]    opcode,
	output logic [cpuPkg::dataWidth-1:0]    operand,
	output logic [cpuPkg::addrWidth-1:0]    pc,
	output logic [cpuPkg::dataWidth-1:0]    acc,
	output logic                            zero,
	output logic                            carry,
	output logic                            outValid,
	output logic [cpuPkg::dataWidth-1:0]    outData
);

	logic [cpuPkg::dataWidth-1:0] aluB;
	cpuPkg::aluResult_t           aluRes;

	// LDI feeds the operand instead of the memory byte
	assign aluB = immSel ? operand : rdata;

	cpuAlu cpuAlu_inst (
		.aluSel (aluSel),
		.a      (acc),
		.b      (aluB),
		.result (aluRes)
	);

	// --------------------------------------------------
	// Instruction registers
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			opcode  <= '0;
			operand <= '0;
		end else begin
			if (opLoad)
				opcode <= rdata;
			if (argLoad)
				operand <= rdata;
		end
	end

	// Program counter, clear wins over load over increment
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			pc <= '0;
		end else if (pcClear) begin
			pc <= '0;
		end else if (pcLoad) begin
			pc <= operand;
		end else if (pcInc) begin
			pc <= pc + 1'b1;
		end
	end

	// --------------------------------------------------
	// Accumulator and flags
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			acc   <= '0;
			zero  <= 1'b0;
			carry <= 1'b0;
		end else begin
			if (accLoad)
				acc <= aluRes.value;
			if (flagLoad)
				zero <= aluRes.zero;
			if (carryLoad)
				carry <= aluRes.carry; // ADD and SUB only
		end
	end

	// Output port
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			outData  <= '0;
			outValid <= 1'b0;
		end else begin
			outValid <= outLoad; // One cycle strobe
			if (outLoad)
				outData <= acc;
		end
	end

endmodule

`default_nettype wire

// File: cpuMemory.sv
`timescale 1ns/10ps
`default_nettype none

module cpuMemory (
	input  logic                            clk,
	input  logic                            nRst,
	input  logic                            coreActive,
	input  cpuPkg::memReq_t                 cpuReq,
	input  cpuPkg::memReq_t                 hostReq,
	output logic [cpuPkg::dataWidth-1:0]    rdata
);

	logic [cpuPkg::dataWidth-1:0] mem [cpuPkg::memDepth];
	cpuPkg::memReq_t              req;

	// Core owns the memory while running
	assign req = coreActive ? cpuReq : hostReq;

	assign rdata = mem[req.address]; // Combinational read

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			for (int i = 0; i < cpuPkg::memDepth; i++) begin
				mem[i] <= cpuPkg::bootImage[i]; // Boot program
			end
		end else if (req.we) begin
			mem[req.address] <= req.wdata;
		end
	end

endmodule

`default_nettype wire

// File: cpuPkg.sv
`default_nettype none

package cpuPkg;

	// --------------------------------------------------
	// Sizes
	localparam int dataWidth = 8;
	localparam int addrWidth = 8;
	localparam int memDepth  = 256;

	// --------------------------------------------------
	// Opcodes, unknown values run as no-op
	localparam logic [dataWidth-1:0] opLda = 8'h01;
	localparam logic [dataWidth-1:0] opSta = 8'h02;
	localparam logic [dataWidth-1:0] opAdd = 8'h03;
	localparam logic [dataWidth-1:0] opSub = 8'h04;
	localparam logic [dataWidth-1:0] opAnd = 8'h05;
	localparam logic [dataWidth-1:0] opXor = 8'h06;
	localparam logic [dataWidth-1:0] opLdi = 8'h07; // Immediate load
	localparam logic [dataWidth-1:0] opJmp = 8'h08;
	localparam logic [dataWidth-1:0] opJz  = 8'h09;
	localparam logic [dataWidth-1:0] opJc  = 8'h0A;
	localparam logic [dataWidth-1:0] opOut = 8'h0B;
	localparam logic [dataWidth-1:0] opHlt = 8'h0F;

	// --------------------------------------------------
	// Types
	typedef enum logic [2:0] {
		aluPass,
		aluAdd,
		aluSub,
		aluAnd,
		aluXor
	} aluOp_t;

	typedef enum logic [1:0] {
		stHalted,
		stFetchOp,
		stFetchArg,
		stExecute
	} ctrlState_t;

	typedef struct packed {
		logic                 we;
		logic [addrWidth-1:0] address;
		logic [dataWidth-1:0] wdata;
	} memReq_t;

	typedef struct packed {
		logic [dataWidth-1:0] value;
		logic                 zero;
		logic                 carry;
	} aluResult_t;

	// --------------------------------------------------
	// Reset contents: running sum of bytes 128..131, carry flag, store to 132
	localparam logic [dataWidth-1:0] bootImage [memDepth] = '{
		0:   8'h01, 1:   8'h80, // LDA 128
		2:   8'h0B, 3:   8'h00, // OUT
		4:   8'h03, 5:   8'h81, // ADD 129
		6:   8'h0B, 7:   8'h00,
		8:   8'h03, 9:   8'h82, // ADD 130
		10:  8'h0B, 11:  8'h00,
		12:  8'h03, 13:  8'h83, // ADD 131, sets carry
		14:  8'h0B, 15:  8'h00,
		16:  8'h02, 17:  8'h84, // STA 132
		18:  8'h0A, 19:  8'h16, // JC 22
		20:  8'h0F, 21:  8'h00, // HLT without carry
		22:  8'h07, 23:  8'h01, // LDI 1
		24:  8'h0B, 25:  8'h00, // OUT carry marker
		26:  8'h0F, 27:  8'h00, // HLT
		128: 8'h12,
		129: 8'h34,
		130: 8'h56,
		131: 8'h78,
		default: 8'h00
	};

endpackage

`default_nettype wire

// File: cpuTbTasks.svh
`ifndef cpuTbTasksSvh
`define cpuTbTasksSvh

// --------------------------------------------------
// Helpers
task automatic applyReset();
	@(negedge clk);
	nRst = 1'b0;
	repeat (3) @(negedge clk);
	nRst = 1'b1;
endtask

task automatic checkValue(input string what, input int got, input int exp);
	assert (got == exp) else begin
		errorCount++;
		$display("mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
	end
endtask

task automatic hostWrite(input logic [7:0] addr, input logic [7:0] data);
	@(negedge clk);
	hostReq.we      = 1'b1;
	hostReq.address = addr;
	hostReq.wdata   = data;
	@(negedge clk);
	hostReq.we = 1'b0;
endtask

task automatic hostRead(input logic [7:0] addr, output logic [7:0] data);
	@(negedge clk);
	hostReq.we      = 1'b0;
	hostReq.address = addr;
	#1;
	data = hostRdata; // Combinational read
endtask

task automatic loadProgram(input logic [7:0] image [$]);
	foreach (image[i])
		hostWrite(8'(i), image[i]);
endtask

task automatic emit(input logic [7:0] op, input logic [7:0] arg);
	prog.push_back(op);
	prog.push_back(arg);
endtask

// Optional second start pulse and host writes while the core runs
task automatic runUntilHalt(input int restartAt, input bit hostPoke);
	outQ.delete();
	@(negedge clk);
	start      = 1'b1;
	lastCycles = 0;
	do begin
		@(negedge clk);
		lastCycles++;
		start = (lastCycles == restartAt) && !halted;
		if (outValid)
			outQ.push_back(outData);
		hostReq.we = hostPoke && !halted;
		if (hostPoke) begin
			hostReq.address = lockAddr;
			hostReq.wdata   = 8'(lastCycles);
		end
	end while (!halted && lastCycles < runLimit);
	start      = 1'b0;
	hostReq.we = 1'b0;
	assert (halted) else begin
		errorCount++;
		$display("Core did not halt within %0d cycles", runLimit);
	end
endtask

task automatic checkOutputs(input string what, input logic [7:0] exp [$]);
	checkValue({what, " output count"}, outQ.size(), exp.size());
	foreach (exp[i])
		if (i < outQ.size())
			checkValue($sformatf("%s output %0d", what, i), outQ[i], exp[i]);
endtask

// LDA a, op b, OUT, then optionally the carry as 1 or 0
task automatic emitOpBlock(input logic [7:0] op, input bit reportCarry);
	emit(cpuPkg::opLda, aAddr);
	emit(op, bAddr);
	emit(cpuPkg::opOut, 8'h00);
	if (reportCarry) begin
		emit(cpuPkg::opLdi, 8'h01);
		emit(cpuPkg::opJc, 8'(prog.size() + 4)); // Skip LDI 0
		emit(cpuPkg::opLdi, 8'h00);
		emit(cpuPkg::opOut, 8'h00);
	end
endtask

// --------------------------------------------------
// Directed tests
task automatic hostLoadReadback();
	logic [7:0] addrs [16];
	logic [7:0] data [16];
	logic [7:0] got;
	checkValue("halted after reset", halted, 1);
	checkValue("outValid after reset", outValid, 0);
	for (int i = 0; i < 16; i++) begin
		addrs[i] = 8'(128 + i * 8 + $urandom_range(7)); // Distinct addresses
		data[i]  = 8'($urandom);
		hostWrite(addrs[i], data[i]);
	end
	for (int i = 0; i < 16; i++) begin
		hostRead(addrs[i], got);
		checkValue($sformatf("readback of 0x%0h", addrs[i]), got, data[i]);
	end
endtask

task automatic bootProgram();
	logic [7:0] exp [$];
	logic [8:0] sum;
	logic [7:0] got;
	sum = {1'b0, cpuPkg::bootImage[128]};
	exp.push_back(sum[7:0]);
	for (int k = 129; k <= 131; k++) begin
		sum = {1'b0, sum[7:0]} + {1'b0, cpuPkg::bootImage[k]};
		exp.push_back(sum[7:0]);
	end
	if (sum[8])
		exp.push_back(8'h01);
	runUntilHalt(0, 1'b0);
	checkOutputs("boot program", exp);
	hostRead(8'd132, got);
	checkValue("boot store to 132", got, sum[7:0]);
endtask

task automatic aluOperations();
	logic [7:0] exp [$];
	logic [7:0] a;
	logic [7:0] b;
	int         s;
	prog.delete();
	emitOpBlock(cpuPkg::opAdd, 1'b1);
	emitOpBlock(cpuPkg::opSub, 1'b1);
	emitOpBlock(cpuPkg::opAnd, 1'b0);
	emitOpBlock(cpuPkg::opXor, 1'b0);
	emit(cpuPkg::opHlt, 8'h00);
	loadProgram(prog);
	repeat (8) begin
		a = 8'($urandom);
		b = 8'($urandom);
		hostWrite(aAddr, a);
		hostWrite(bAddr, b);
		s = int'(a) + int'(b);
		exp.delete();
		exp.push_back(8'(s % 256));
		exp.push_back((s > 255) ? 8'h01 : 8'h00);
		exp.push_back(a - b);
		exp.push_back({7'd0, (b > a)}); // Borrow
		exp.push_back(a & b);
		exp.push_back(a ^ b);
		runUntilHalt(0, 1'b0);
		checkOutputs($sformatf("alu a=0x%0h b=0x%0h", a, b), exp);
	end
endtask

task automatic branchAndImmediate();
	logic [7:0] exp [$];
	int         n;
	n = 2 + $urandom_range(6);
	prog.delete();
	emit(cpuPkg::opLdi, 8'(n));     // 0
	emit(cpuPkg::opSub, decAddr);   // 2 is the loop top
	emit(cpuPkg::opOut, 8'h00);     // 4
	emit(cpuPkg::opJz, 8'd10);      // 6
	emit(cpuPkg::opJmp, 8'd2);      // 8
	emit(undefOp, decAddr);         // 10
	emit(cpuPkg::opOut, 8'h00);
	emit(cpuPkg::opHlt, 8'h00);
	loadProgram(prog);
	hostWrite(decAddr, 8'h01);
	for (int v = n - 1; v >= 0; v--)
		exp.push_back(8'(v));
	exp.push_back(8'h00); // acc untouched by undefined opcode
	runUntilHalt(0, 1'b0);
	checkOutputs("countdown", exp);
endtask

task automatic runTiming();
	logic [7:0] exp [$];
	prog.delete();
	emit(cpuPkg::opLdi, 8'h5A);
	emit(cpuPkg::opOut, 8'h00);
	emit(cpuPkg::opOut, 8'h00);
	emit(cpuPkg::opHlt, 8'h00);
	loadProgram(prog);
	exp.push_back(8'h5A);
	exp.push_back(8'h5A);
	runUntilHalt(0, 1'b0);
	checkValue("cycles from start to halted", lastCycles, 3 * 4 + 1);
	checkOutputs("timing", exp); // Count catches long outValid pulses
	runUntilHalt(5, 1'b0);
	checkValue("cycles with start while running", lastCycles, 3 * 4 + 1);
	checkOutputs("start while running", exp);
endtask

task automatic hostLockout();
	logic [7:0] exp [$];
	logic [7:0] got;
	hostWrite(lockAddr, 8'hA5);
	exp.push_back(8'h5A);
	exp.push_back(8'h5A);
	runUntilHalt(0, 1'b1); // Timing program still loaded
	checkOutputs("host lockout", exp);
	hostRead(lockAddr, got);
	checkValue("memory after host writes while running", got, 8'hA5);
endtask

`endif

// File: cpuTb.sv
`timescale 1ns/10ps
`default_nettype none

module cpuTb;

	localparam int runLimit   = 200; // Cycle bound of one program run
	localparam int runCount   = 13;
	localparam int hostCycles = 800; // Loads, readbacks and resets
	localparam int watchdogNs = 2 * (runLimit * runCount + hostCycles) * 10;

	localparam logic [7:0] aAddr    = 8'hF0; // ALU test operands
	localparam logic [7:0] bAddr    = 8'hF1;
	localparam logic [7:0] decAddr  = 8'hF2; // Countdown step
	localparam logic [7:0] lockAddr = 8'd200;
	localparam logic [7:0] undefOp  = 8'h0C;

	logic                         clk;
	logic                         nRst;
	logic                         start;
	cpuPkg::memReq_t              hostReq;
	logic [cpuPkg::dataWidth-1:0] hostRdata;
	logic [cpuPkg::dataWidth-1:0] outData;
	logic                         outValid;
	logic                         halted;

	int         errorCount;
	int         lastCycles; // Start pulse to halted
	logic [7:0] outQ [$];
	logic [7:0] prog [$];

	cpuTop cpuTop_inst (
		.clk       (clk),
		.nRst      (nRst),
		.start     (start),
		.hostReq   (hostReq),
		.hostRdata (hostRdata),
		.outData   (outData),
		.outValid  (outValid),
		.halted    (halted)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	`include "cpuTbTasks.svh"

	// --------------------------------------------------
	// Watchdog
	initial begin
		#(watchdogNs);
		$display("Timeout: the tests did not finish within %0d ns", watchdogNs);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// --------------------------------------------------
	// Test sequence
	initial begin
		nRst       = 1'b0;
		start      = 1'b0;
		hostReq    = '0;
		errorCount = 0;
		lastCycles = 0;
		void'($urandom(52));
		applyReset();
		hostLoadReadback();
		applyReset(); // Reload boot image
		bootProgram();
		aluOperations();
		branchAndImmediate();
		runTiming();
		hostLockout();
		$display("Errors: %0d", errorCount);
		if (errorCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: cpuTop.sv
`timescale 1ns/10ps
`default_nettype none

module cpuTop (
	input  logic                            clk,
	input  logic                            nRst,
	input  logic                            start,
	input  cpuPkg::memReq_t                 hostReq,
	output logic [cpuPkg::dataWidth-1:0]    hostRdata,
	output logic [cpuPkg::dataWidth-1:0]    outData,
	output logic                            outValid,
	output logic                            halted
);

	cpuPkg::memReq_t              cpuReq;
	cpuPkg::aluOp_t               aluSel;
	logic [cpuPkg::dataWidth-1:0] rdata;
	logic [cpuPkg::dataWidth-1:0] opcode;
	logic [cpuPkg::dataWidth-1:0] operand;
	logic [cpuPkg::addrWidth-1:0] pc;
	logic [cpuPkg::dataWidth-1:0] acc;
	logic                         zero;
	logic                         carry;
	logic                         coreActive;
	logic                         opLoad;
	logic                         argLoad;
	logic                         accLoad;
	logic                         flagLoad;
	logic                         carryLoad;
	logic                         pcInc;
	logic                         pcLoad;
	logic                         pcClear;
	logic                         outLoad;
	logic                         immSel;

	assign hostRdata = rdata; // Same read port as the core

	cpuMemory cpuMemory_inst (
		.clk        (clk),
		.nRst       (nRst),
		.coreActive (coreActive),
		.cpuReq     (cpuReq),
		.hostReq    (hostReq),
		.rdata      (rdata)
	);

	cpuDatapath cpuDatapath_inst (
		.clk       (clk),
		.nRst      (nRst),
		.rdata     (rdata),
		.opLoad    (opLoad),
		.argLoad   (argLoad),
		.accLoad   (accLoad),
		.flagLoad  (flagLoad),
		.carryLoad (carryLoad),
		.pcInc     (pcInc),
		.pcLoad    (pcLoad),
		.pcClear   (pcClear),
		.outLoad   (outLoad),
		.immSel    (immSel),
		.aluSel    (aluSel),
		.opcode    (opcode),
		.operand   (operand),
		.pc        (pc),
		.acc       (acc),
		.zero      (zero),
		.carry     (carry),
		.outValid  (outValid),
		.outData   (outData)
	);

	cpuControl cpuControl_inst (
		.clk        (clk),
		.nRst       (nRst),
		.start      (start),
		.opcode     (opcode),
		.operand    (operand),
		.pc         (pc),
		.acc        (acc),
		.zero       (zero),
		.carry      (carry),
		.cpuReq     (cpuReq),
		.coreActive (coreActive),
		.halted     (halted),
		.opLoad     (opLoad),
		.argLoad    (argLoad),
		.accLoad    (accLoad),
		.flagLoad   (flagLoad),
		.carryLoad  (carryLoad),
		.pcInc      (pcInc),
		.pcLoad     (pcLoad),
		.pcClear    (pcClear),
		.outLoad    (outLoad),
		.immSel     (immSel),
		.aluSel     (aluSel)
	);

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
cpuPkg.sv
cpuAlu.sv
cpuMemory.sv
cpuDatapath.sv
cpuControl.sv
cpuTop.sv
cpuTb.sv
